// File: bp_defs.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor sizes
// table, counter, data and opcode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// table geometry
`define BP_ENTRIES 4 // entries in the table
`define BP_IDX_W 2 // index bits, must divide BP_FOLD_W
`define BP_FOLD_W 16 // low pc bits folded into the index

// confidence counter
`define BP_CONF_W 3
`define BP_CONF_MAX 7 // value written on allocate

// datapath
`define BP_XLEN 32
`define BP_NREGS 32 // architectural registers

// rv32 conditional branch major opcode
`define BP_OPC_BRANCH 7'b1100011

`endif

// File: bp_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor types
// table entry, write, retire, writeback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "bp_defs.svh"

package bp_pkg;

	typedef logic [`BP_XLEN-1:0] word_t;
	typedef logic [`BP_IDX_W-1:0] tbl_idx_t;
	typedef logic [$clog2(`BP_NREGS)-1:0] reg_idx_t;
	typedef logic [`BP_CONF_W-1:0] conf_t;

	// b-type layout, msb first
	typedef struct packed {
		logic [6:0] imm_hi; // imm[12|10:5]
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3; // condition select
		logic [4:0] imm_lo; // imm[4:1|11]
		logic [6:0] opcode;
	} b_fields_t;

	// raw word for storage, fields for decode
	typedef union packed {
		word_t raw;
		b_fields_t b;
	} inst_u;

	typedef struct packed {
		word_t tag; // full branch pc
		conf_t conf; // 0 means empty
		inst_u inst;
	} tbl_entry_t;

	typedef struct packed {
		logic we_full; // allocate
		logic we_conf; // strengthen or weaken
		tbl_idx_t idx;
		tbl_entry_t entry;
	} tbl_wr_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		inst_u inst;
	} retire_t;

	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t data;
	} wb_t;

	// xor of pc[15:0] in index-wide slices
	function automatic tbl_idx_t bp_index(input word_t pc);
		tbl_idx_t idx;
		idx = '0;
		for (int i = 0; i < `BP_FOLD_W / `BP_IDX_W; i++) begin
			idx ^= pc[i*`BP_IDX_W +: `BP_IDX_W];
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// File: retire_update.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// retire side table update
// allocate, strengthen or weaken
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "bp_defs.svh"

module retire_update (
	input  logic               clk,
	input  logic               arst_n,
	input  bp_pkg::retire_t    retire,
	input  bp_pkg::tbl_entry_t entry_at_retire, // indexed entry, combinational
	output bp_pkg::tbl_idx_t   retire_idx,
	output bp_pkg::tbl_wr_t    tbl_wr
);

	logic is_branch;
	logic tag_match;

	assign retire_idx = bp_pkg::bp_index(retire.pc);
	assign is_branch = retire.valid && (retire.inst.b.opcode == `BP_OPC_BRANCH);
	assign tag_match = (entry_at_retire.tag == retire.pc);

	always_comb begin
		tbl_wr = '0;
		tbl_wr.idx = retire_idx;
		tbl_wr.entry = entry_at_retire; // conf write keeps tag and inst
		if (is_branch) begin
			if (entry_at_retire.conf == '0) begin
				// empty or worn out, take the slot
				tbl_wr.we_full = 1'b1;
				tbl_wr.entry.tag = retire.pc;
				tbl_wr.entry.inst.raw = retire.inst.raw;
				tbl_wr.entry.conf = bp_pkg::conf_t'(`BP_CONF_MAX);
			end else if (tag_match) begin
				tbl_wr.we_conf = 1'b1;
				if (entry_at_retire.conf != bp_pkg::conf_t'(`BP_CONF_MAX)) begin
					tbl_wr.entry.conf = entry_at_retire.conf + 1'b1; // saturates at max
				end
			end else begin
				tbl_wr.we_conf = 1'b1; // other branch on this index
				tbl_wr.entry.conf = entry_at_retire.conf - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: branch_table.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch table storage
// registered fetch read, one write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "bp_defs.svh"

module branch_table (
	input  logic               clk,
	input  logic               arst_n,
	input  bp_pkg::tbl_idx_t   retire_idx,
	output bp_pkg::tbl_entry_t entry_at_retire,
	input  bp_pkg::tbl_wr_t    tbl_wr,
	input  logic               fetch_valid,
	input  bp_pkg::word_t      fetch_pc,
	output bp_pkg::tbl_entry_t rd_entry,
	output logic               rd_valid
);

	bp_pkg::tbl_entry_t tbl [`BP_ENTRIES];
	bp_pkg::tbl_idx_t   fetch_idx;

	assign fetch_idx = bp_pkg::bp_index(fetch_pc);

	// update side view for retire_update
	assign entry_at_retire = tbl[retire_idx];

	// writes, cleared on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `BP_ENTRIES; i++) begin
				tbl[i] <= '0;
			end
		end else if (tbl_wr.we_full) begin
			tbl[tbl_wr.idx] <= tbl_wr.entry;
		end else if (tbl_wr.we_conf) begin
			tbl[tbl_wr.idx].conf <= tbl_wr.entry.conf; // counter only
		end
	end

	// fetch read, sees the entry from before a same-edge write
	always_ff @(posedge clk) begin
		rd_entry <= tbl[fetch_idx];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= fetch_valid; // tracks rd_entry
		end
	end

endmodule

`default_nettype wire

// File: branch_lookup.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch lookup
// hit check and condition on live operands
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module branch_lookup (
	input  logic               clk,
	input  logic               arst_n,
	input  bp_pkg::word_t      fetch_pc,
	input  bp_pkg::tbl_entry_t rd_entry,
	input  logic               rd_valid,
	output bp_pkg::reg_idx_t   rs1_idx,
	output bp_pkg::reg_idx_t   rs2_idx,
	input  bp_pkg::word_t      rs1_val,
	input  bp_pkg::word_t      rs2_val,
	output logic               hit,
	output logic               prediction
);

	bp_pkg::word_t pc_q; // pc of the entry now in rd_entry
	logic          taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= fetch_pc; // same edge as the table read
		end
	end

	// operand registers straight from the stored word
	assign rs1_idx = rd_entry.inst.b.rs1;
	assign rs2_idx = rd_entry.inst.b.rs2;

	always_comb begin
		case (rd_entry.inst.b.funct3)
			3'b000: taken = (rs1_val == rs2_val); // beq
			3'b001: taken = (rs1_val != rs2_val); // bne
			3'b100: taken = ($signed(rs1_val) < $signed(rs2_val)); // blt
			3'b101: taken = ($signed(rs1_val) >= $signed(rs2_val)); // bge
			3'b110: taken = (rs1_val < rs2_val); // bltu
			3'b111: taken = (rs1_val >= rs2_val); // bgeu
			default: taken = 1'b0; // 010 and 011 unused
		endcase
	end

	// full pc tag, counter must be live
	assign hit = rd_valid && (rd_entry.conf != '0) && (rd_entry.tag == pc_q);
	assign prediction = hit && taken;

endmodule

`default_nettype wire

// File: shadow_regfile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shadow register file
// writeback copy, two async reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "bp_defs.svh"

module shadow_regfile (
	input  logic             clk,
	input  logic             arst_n,
	input  bp_pkg::wb_t      wb,
	input  bp_pkg::reg_idx_t rs1_idx,
	input  bp_pkg::reg_idx_t rs2_idx,
	output bp_pkg::word_t    rs1_val,
	output bp_pkg::word_t    rs2_val
);

	bp_pkg::word_t regs [`BP_NREGS];

	// x0 never written so it stays at its reset zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `BP_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rs1_val = regs[rs1_idx];
	assign rs2_val = regs[rs2_idx];

endmodule

`default_nettype wire

// File: branch_predictor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor top
// update, table, lookup, shadow regs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module branch_predictor (
	input  logic            clk,
	input  logic            arst_n,
	input  bp_pkg::retire_t retire,
	input  bp_pkg::wb_t     wb,
	input  logic            fetch_valid,
	input  bp_pkg::word_t   fetch_pc,
	output logic            hit,
	output logic            prediction
);

	bp_pkg::tbl_idx_t   retire_idx;
	bp_pkg::tbl_entry_t entry_at_retire;
	bp_pkg::tbl_wr_t    tbl_wr;
	bp_pkg::tbl_entry_t rd_entry;
	logic               rd_valid;
	bp_pkg::reg_idx_t   rs1_idx;
	bp_pkg::reg_idx_t   rs2_idx;
	bp_pkg::word_t      rs1_val;
	bp_pkg::word_t      rs2_val;

	// write producer
	retire_update i_retire_update (
		.clk             (clk),
		.arst_n          (arst_n),
		.retire          (retire),
		.entry_at_retire (entry_at_retire),
		.retire_idx      (retire_idx),
		.tbl_wr          (tbl_wr)
	);

	branch_table i_branch_table (
		.clk             (clk),
		.arst_n          (arst_n),
		.retire_idx      (retire_idx),
		.entry_at_retire (entry_at_retire),
		.tbl_wr          (tbl_wr),
		.fetch_valid     (fetch_valid),
		.fetch_pc        (fetch_pc),
		.rd_entry        (rd_entry),
		.rd_valid        (rd_valid)
	);

	// one cycle after the fetch edge
	branch_lookup i_branch_lookup (
		.clk        (clk),
		.arst_n     (arst_n),
		.fetch_pc   (fetch_pc),
		.rd_entry   (rd_entry),
		.rd_valid   (rd_valid),
		.rs1_idx    (rs1_idx),
		.rs2_idx    (rs2_idx),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.hit        (hit),
		.prediction (prediction)
	);

	shadow_regfile i_shadow_regfile (
		.clk     (clk),
		.arst_n  (arst_n),
		.wb      (wb),
		.rs1_idx (rs1_idx),
		.rs2_idx (rs2_idx),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val)
	);

endmodule

`default_nettype wire

// File: bp_asserts.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predictor output checker
// bound into the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module bp_asserts (
	input logic clk,
	input logic arst_n,
	input logic fetch_valid,
	input logic hit,
	input logic prediction
);

	int n_fail_pred = 0; // failures per rule
	int n_fail_idle = 0;
	int n_fail_x = 0;

	// taken only on a hit
	pred_needs_hit: assert property (@(posedge clk) disable iff (!arst_n)
		!(prediction && !hit))
	else begin
		$error("prediction high while hit is low");
		n_fail_pred++;
	end

	// no lookup at this edge, no hit in the next cycle
	idle_no_hit: assert property (@(posedge clk) disable iff (!arst_n)
		!fetch_valid |=> !hit)
	else begin
		$error("hit high after a cycle without fetch_valid");
		n_fail_idle++;
	end

	known_outputs: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({hit, prediction}))
	else begin
		$error("hit or prediction unknown after reset");
		n_fail_x++;
	end

endmodule

bind branch_predictor bp_asserts i_bp_asserts (
	.clk         (clk),
	.arst_n      (arst_n),
	.fetch_valid (fetch_valid),
	.hit         (hit),
	.prediction  (prediction)
);

`default_nettype wire

// File: tb_branch_predictor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor testbench
// vector driven, checks hit and prediction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module tb_branch_predictor;

	localparam int CLK_PERIOD = 4; // ns
	localparam int RST_CYCLES = 8;
	localparam int MAX_VEC = 96; // lines in the vector file
	localparam int MARGIN = 40; // watchdog slack, cycles

	logic            clk;
	logic            arst_n;
	bp_pkg::retire_t retire;
	bp_pkg::wb_t     wb;
	logic            fetch_valid;
	bp_pkg::word_t   fetch_pc;
	logic            hit;
	logic            prediction;

	logic [31:0] vec_mem [4*MAX_VEC]; // op, a, b, c per line
	int n_vec;
	int n_cycles; // drive cycles the vectors need
	int n_checks;
	int n_errors;
	int test_errors;
	int n_tests;
	int n_tests_failed;

	branch_predictor i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.retire      (retire),
		.wb          (wb),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.hit         (hit),
		.prediction  (prediction)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// reads the file, counts lines up to the end marker
	task automatic load_vectors();
		n_vec = 0;
		n_cycles = 0;
		$readmemh("bp_vectors.txt", vec_mem);
		while (n_vec < MAX_VEC && vec_mem[4*n_vec] !== 32'hf) begin
			// retire lines repeat c times
			n_cycles += 2 + ((vec_mem[4*n_vec] == 32'h1) ? int'(vec_mem[4*n_vec+3]) : 0);
			n_vec++;
		end
		if (n_vec == MAX_VEC) begin
			$display("vector file has no end marker or is missing");
			n_errors++;
		end
	endtask

	// one rising edge, all strobes driven together
	task automatic drive(input bp_pkg::retire_t r, input bp_pkg::wb_t w,
			input logic fv, input bp_pkg::word_t pc);
		@(posedge clk);
		retire <= r;
		wb <= w;
		fetch_valid <= fv;
		fetch_pc <= pc;
	endtask

	task automatic check_outputs(input bp_pkg::word_t pc, input logic [1:0] expect_hp);
		n_checks++;
		if (hit !== expect_hp[1]) begin
			$display("CHECK FAILED hit at pc %h: got %h, expected %h", pc, hit, expect_hp[1]);
			test_errors++;
		end
		if (prediction !== expect_hp[0]) begin
			$display("CHECK FAILED prediction at pc %h: got %h, expected %h",
				pc, prediction, expect_hp[0]);
			test_errors++;
		end
	endtask

	task automatic report_test(input int num);
		n_tests++;
		n_errors += test_errors;
		if (test_errors == 0) begin
			$display("test %0d passed", num);
		end else begin
			n_tests_failed++;
			$display("test %0d failed with %0d wrong values", num, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		logic [31:0] op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] arg_c;
		bp_pkg::retire_t r;
		bp_pkg::wb_t w;
		int n_asrt;
		arst_n = 1'b0;
		retire = '0;
		wb = '0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		n_errors = 0;
		n_checks = 0;
		test_errors = 0;
		n_tests = 0;
		n_tests_failed = 0;
		load_vectors();
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int k = 0; k < n_vec; k++) begin
			op = vec_mem[4*k];
			arg_a = vec_mem[4*k+1];
			arg_b = vec_mem[4*k+2];
			arg_c = vec_mem[4*k+3];
			r = '0;
			w = '0;
			case (op)
				32'h1: begin
					r.valid = 1'b1;
					r.pc = arg_a;
					r.inst.raw = arg_b;
					repeat ((arg_c == 0) ? 1 : arg_c) drive(r, '0, 1'b0, fetch_pc);
				end
				32'h2: begin
					w.valid = 1'b1;
					w.rd = arg_a[4:0];
					w.data = arg_b;
					drive('0, w, 1'b0, fetch_pc);
				end
				32'h3: begin
					drive('0, '0, 1'b1, arg_a); // read at the next edge
					drive('0, '0, 1'b0, arg_a);
					@(negedge clk); // outputs settled after the read edge
					check_outputs(arg_a, arg_c[1:0]);
				end
				32'h4: report_test(int'(arg_a));
				default: begin
					$display("vector line %0d holds an unknown command %h", k, op);
					n_errors++;
				end
			endcase
		end
		drive('0, '0, 1'b0, fetch_pc);
		n_errors += test_errors; // checks after the last test marker
		n_asrt = i_dut.i_bp_asserts.n_fail_pred + i_dut.i_bp_asserts.n_fail_idle
			+ i_dut.i_bp_asserts.n_fail_x;
		$display("tests %0d, tests failed %0d, checks %0d, errors %0d, assertion failures %0d",
			n_tests, n_tests_failed, n_checks, n_errors, n_asrt);
		if (n_errors == 0 && n_tests_failed == 0 && n_asrt == 0 && n_checks > 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// hang guard, sized from the vector file
	initial begin
		int limit;
		#1;
		limit = (n_cycles * 4 + RST_CYCLES + MARGIN) * CLK_PERIOD;
		#(limit);
		$display("watchdog expired after %0d ns, the vector run did not finish", limit);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bp_vectors.txt
// op a b c in hex: 1 retire pc inst c=repeat, 2 writeback rd data, 3 lookup pc - c={hit,pred}
// 4 end of test a=number, f end of vectors
3 00000100 0 0 // reset state
3 00000000 0 0
4 1 0 0
2 1 00000005 0 // beq x1,x2 at 0x100, index 1
2 2 00000005 0
1 00000100 00208063 1
3 00000100 0 3
3 00010100 0 0 // same index, other tag
2 2 00000006 0
3 00000100 0 2
4 2 0 0
2 3 00000007 0 // bne x3,x4 at 0x200
2 4 00000007 0
1 00000200 00419063 1
3 00000200 0 2
2 3 00000008 0
3 00000200 0 3
2 5 ffffffff 0 // blt at 0x300, bltu at 0x50, both on x5,x6
2 6 00000001 0
1 00000300 0062c063 1
3 00000300 0 3
1 00000050 0062e063 1
3 00000050 0 2
2 5 00000000 0
3 00000050 0 3
2 5 00000002 0
3 00000300 0 2
4 3 0 0
1 00000004 00208063 7 // beq at 0x4, index 1, drains A
3 00000100 0 0
1 00000004 00208063 1
3 00000004 0 2
3 00000100 0 0
4 4 0 0
1 00000004 00208063 3 // saturates at 7
1 00000100 00208063 6
3 00000004 0 2
1 00000100 00208063 1
3 00000004 0 0
3 00000100 0 0
4 5 0 0
1 00000004 00500093 1 // addi, no allocate
3 00000004 0 0
1 00000004 00700063 1 // beq x0,x7
3 00000004 0 3
2 0 12345678 0
3 00000004 0 3
4 6 0 0
f 0 0 0

// File: src.f
+incdir+.
bp_pkg.sv
retire_update.sv
branch_table.sv
branch_lookup.sv
shadow_regfile.sv
branch_predictor.sv
bp_asserts.sv
tb_branch_predictor.sv

// File: Makefile
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
